//--- rtl/lease_pkg.sv
package lease_pkg;

	// cache geometry
	// one lease register per cache block
	localparam int N_BLOCKS = 8;

	// lease counter width
	// a lease of zero means the block has expired
	localparam int LEASE_W = 6;

	// block index width, follows the block count
	localparam int BLOCK_IDX_W = $clog2(N_BLOCKS);

	// one lease value
	typedef logic [LEASE_W-1:0] lease_t;

	// one block index
	typedef logic [BLOCK_IDX_W-1:0] block_idx_t;

	// one bit per block, bit k belongs to block k
	typedef logic [N_BLOCKS-1:0] block_vec_t;

	// whole lease table, element k is the lease of block k
	typedef lease_t [N_BLOCKS-1:0] lease_array_t;

	// lease load request from the cache controller
	typedef struct packed {
		// load strobe
		logic write;
		// target block
		block_idx_t addr;
		// new lease value
		lease_t lease;
	} lease_update_t;

	// victim choice as seen by the replacement logic
	typedef struct packed {
		// set when the named block has a zero lease
		logic expired;
		// block to evict
		block_idx_t idx;
	} victim_t;

endpackage

//--- rtl/lowest_index_encoder.sv
`timescale 1ns/100ps

// priority encoder over one block vector
// lowest set bit wins, empty vector gives index zero
module lowest_index_encoder (
	input  lease_pkg::block_vec_t vec_i,
	output lease_pkg::block_idx_t idx_o
);

	import lease_pkg::*;

	// working copy of the result
	block_idx_t idx;

	always_comb begin
		// default for an empty vector
		idx = '0;

		// scan from the top bit down
		// each hit overwrites the previous one,
		// so the last hit is the lowest set bit
		for (int k = N_BLOCKS - 1; k >= 0; k--) begin
			if (vec_i[k]) begin
				idx = block_idx_t'(k);
			end
		end
	end

	// purely combinational
	// no clock, no reset
	assign idx_o = idx;

endmodule

//--- rtl/lease_register_file.sv
`timescale 1ns/100ps

// lease registers, one per cache block
// loaded by the cache controller, counted down on every access tick
module lease_register_file (
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  lease_pkg::lease_update_t update_i,
	input  logic                    tick_i,
	output lease_pkg::lease_array_t  leases_o
);

	import lease_pkg::*;

	// current lease table
	lease_array_t leases_q;
	// next lease table
	lease_array_t leases_d;

	// decoded write enables
	// at most one bit set per cycle
	block_vec_t write_hit;

	// address decode for the load request
	always_comb begin
		for (int k = 0; k < N_BLOCKS; k++) begin
			write_hit[k] = update_i.write && (update_i.addr == block_idx_t'(k));
		end
	end

	// next state per block
	always_comb begin
		// hold by default
		leases_d = leases_q;

		for (int k = 0; k < N_BLOCKS; k++) begin
			if (write_hit[k]) begin
				// write beats tick
				// new lease is loaded undecremented
				leases_d[k] = update_i.lease;
			end else if (tick_i && (leases_q[k] != '0)) begin
				// countdown, saturates at zero
				leases_d[k] = leases_q[k] - lease_t'(1);
			end
		end
	end

	// lease table register
	// sync active low clear, all blocks start expired
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			leases_q <= '0;
		end else begin
			leases_q <= leases_d;
		end
	end

	// table goes straight out
	// selector and arbiter both read it
	assign leases_o = leases_q;

endmodule

//--- rtl/approx_lease_selector.sv
`timescale 1ns/100ps

// approximate maximum lease finder
// looks at the table one bit slice at a time, top slice first;
// the winner is the lowest block with a one in the highest
// bit position where any block has a one
module approx_lease_selector (
	input  lease_pkg::lease_array_t leases_i,
	output lease_pkg::block_idx_t   max_idx_o
);

	import lease_pkg::*;

	// slice b holds bit b of every lease
	block_vec_t [LEASE_W-1:0] slice_vec;

	// slice has at least one block with this bit set
	logic [LEASE_W-1:0] slice_occ;

	// lowest block index per slice
	block_idx_t slice_idx [LEASE_W];

	// mux chain stage outputs
	// stage b is the pick from slices b and above
	block_idx_t chain_idx [LEASE_W];

	// any slice strictly above or at b is occupied
	// slice 0 never needs this, nothing sits below it
	logic [LEASE_W-1:1] occ_above;

	// transpose the lease table into bit slices
	always_comb begin
		for (int b = 0; b < LEASE_W; b++) begin
			for (int k = 0; k < N_BLOCKS; k++) begin
				slice_vec[b][k] = leases_i[k][b];
			end
		end
	end

	// occupancy per slice
	always_comb begin
		for (int b = 0; b < LEASE_W; b++) begin
			slice_occ[b] = |slice_vec[b];
		end
	end

	// one encoder per bit slice
	for (genvar b = 0; b < LEASE_W; b++) begin : g_slice
		lowest_index_encoder u_slice_enc (
			.vec_i (slice_vec[b]),
			.idx_o (slice_idx[b])
		);
	end

	// mux chain, priority runs from the top slice down
	for (genvar b = 0; b < LEASE_W; b++) begin : g_chain
		if (b == LEASE_W - 1) begin : g_top
			// top slice has nothing above it
			assign chain_idx[b] = slice_idx[b];
			assign occ_above[b] = slice_occ[b];
		end else if (b > 0) begin : g_mid
			// an occupied slice above shadows this one
			assign chain_idx[b] = occ_above[b+1] ? chain_idx[b+1] : slice_idx[b];
			assign occ_above[b] = occ_above[b+1] | slice_occ[b];
		end else begin : g_bottom
			// last stage, falls back to slice 0
			// all zero leases end up here with index 0
			assign chain_idx[b] = occ_above[b+1] ? chain_idx[b+1] : slice_idx[b];
		end
	end

	// bottom of the chain is the answer
	assign max_idx_o = chain_idx[0];

endmodule

//--- rtl/victim_arbiter.sv
`timescale 1ns/100ps

// victim choice
// expired blocks go first, lowest index among them;
// otherwise take the approximate maximum from the selector
module victim_arbiter (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  lease_pkg::lease_array_t leases_i,
	input  lease_pkg::block_idx_t   max_idx_i,
	output lease_pkg::victim_t      victim_o
);

	import lease_pkg::*;

	// blocks whose lease has run out
	block_vec_t expired_vec;

	// lowest expired block
	block_idx_t expired_idx;

	// at least one block expired
	logic any_expired;

	// victim before and after the register
	victim_t victim_d;
	victim_t victim_q;

	// zero lease flags
	always_comb begin
		for (int k = 0; k < N_BLOCKS; k++) begin
			expired_vec[k] = (leases_i[k] == '0);
		end
	end

	// same encoder as the selector slices
	lowest_index_encoder u_expired_enc (
		.vec_i (expired_vec),
		.idx_o (expired_idx)
	);

	assign any_expired = |expired_vec;

	// expired wins over the approximate maximum
	always_comb begin
		victim_d.expired = any_expired;
		if (any_expired) begin
			victim_d.idx = expired_idx;
		end else begin
			victim_d.idx = max_idx_i;
		end
	end

	// victim register
	// one edge behind the lease table, updated every cycle
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			victim_q <= '0;
		end else begin
			victim_q <= victim_d;
		end
	end

	// registered level
	// no handshake, the consumer samples when it needs it
	assign victim_o = victim_q;

endmodule

//--- rtl/lease_cache_top.sv
`timescale 1ns/100ps

// lease based victim selection
// register file feeds both the selector and the arbiter
module lease_cache_top (
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  lease_pkg::lease_update_t update_i,
	input  logic                    tick_i,
	output lease_pkg::victim_t       victim_o
);

	import lease_pkg::*;

	// lease table, register file out
	lease_array_t leases;

	// approximate maximum, selector out
	block_idx_t max_idx;

	// lease storage and countdown
	lease_register_file u_lease_register_file (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.update_i (update_i),
		.tick_i   (tick_i),
		.leases_o (leases)
	);

	// combinational approximate maximum
	approx_lease_selector u_approx_lease_selector (
		.leases_i  (leases),
		.max_idx_o (max_idx)
	);

	// expired check and victim register
	// two edges from update_i to victim_o in total
	victim_arbiter u_victim_arbiter (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.leases_i  (leases),
		.max_idx_i (max_idx),
		.victim_o  (victim_o)
	);

endmodule

//--- test/lease_cache_assert.sv
`timescale 1ns/100ps

// checker for the lease table and the victim register
module lease_cache_assert (
	input logic                    clock_i,
	input logic                    resetn_i,
	input lease_pkg::lease_update_t update_i,
	input lease_pkg::lease_array_t  leases_i,
	input lease_pkg::victim_t       victim_i
);

	import lease_pkg::*;

	// table as it stood one edge earlier
	lease_array_t leases_prev;

	always @(posedge clock_i) begin
		leases_prev <= leases_i;
	end

	// victim register clears on reset
	assert property (@(posedge clock_i) !resetn_i |=> (victim_i == '0))
		else $error("victim_o not cleared after reset");

	// leases only go up through a write
	for (genvar k = 0; k < N_BLOCKS; k++) begin : g_no_rise
		assert property (@(posedge clock_i) disable iff (!resetn_i)
			!(update_i.write && (update_i.addr == block_idx_t'(k)))
				|=> (leases_i[k] <= $past(leases_i[k])))
			else $error("lease of block %0d rose without a write", k);
	end

	// an expired victim had a zero lease the cycle before
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		victim_i.expired |-> (leases_prev[victim_i.idx] == '0))
		else $error("expired victim %0d had a nonzero lease", victim_i.idx);

endmodule

bind lease_cache_top lease_cache_assert u_lease_cache_assert (
	.clock_i  (clock_i),
	.resetn_i (resetn_i),
	.update_i (update_i),
	.leases_i (leases),
	.victim_i (victim_o)
);

//--- test/tb_lease_cache.sv
`timescale 1ns/100ps

module tb_lease_cache;

	import lease_pkg::*;

	// 100 ns period, half period here
	localparam int HALF_PERIOD = 50;
	// input skew after the rising edge
	localparam int DRIVE_DELAY = 10;
	// tests take roughly 370 cycles, limit at about twice that and more
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int RANDOM_CYCLES = 300;

	logic          clock_i;
	logic          resetn_i;
	lease_update_t update_i;
	logic          tick_i;
	victim_t       victim_o;

	// reference state, leases as they stand after the last edge
	lease_array_t model_leases;
	// victim expected on victim_o after the last edge
	victim_t      exp_victim;

	int error_count;
	int cycle_count;

	lease_cache_top DUT (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.update_i (update_i),
		.tick_i   (tick_i),
		.victim_o (victim_o)
	);

	initial begin
		clock_i = 1'b0;
		forever begin
			#HALF_PERIOD clock_i = ~clock_i;
		end
	end

	// lease table one edge later, register file rules
	function automatic lease_array_t next_leases(lease_array_t cur, lease_update_t upd,
			logic tick);
		lease_array_t nxt;
		nxt = cur;
		for (int k = 0; k < N_BLOCKS; k++) begin
			if (upd.write && (int'(upd.addr) == k)) begin
				nxt[k] = upd.lease;
			end else if (tick && (cur[k] != '0)) begin
				nxt[k] = cur[k] - lease_t'(1);
			end
		end
		return nxt;
	endfunction

	// victim picked from a lease table
	function automatic victim_t expected_victim(lease_array_t lv);
		victim_t v;
		logic found;
		v = '0;
		found = 1'b0;
		// first expired block, counting up
		for (int k = 0; k < N_BLOCKS; k++) begin
			if (!found && (lv[k] == '0)) begin
				found = 1'b1;
				v.expired = 1'b1;
				v.idx = block_idx_t'(k);
			end
		end
		// else highest bit that any lease has, lowest block holding it
		for (int b = LEASE_W - 1; b >= 0; b--) begin
			for (int k = 0; k < N_BLOCKS; k++) begin
				if (!found && lv[k][b]) begin
					found = 1'b1;
					v.idx = block_idx_t'(k);
				end
			end
		end
		return v;
	endfunction

	function automatic victim_t make_victim(logic expired, block_idx_t idx);
		victim_t v;
		v.expired = expired;
		v.idx = idx;
		return v;
	endfunction

	task automatic compare_victim(input string name, input victim_t expected,
			input victim_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("** Error: %s expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic compare_lease(input string name, input lease_t expected,
			input lease_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("** Error: %s expected %h, got %h", name, expected, actual);
		end
	endtask

	// victim and every lease against the model
	task automatic check_state();
		compare_victim("victim_o", exp_victim, victim_o);
		for (int k = 0; k < N_BLOCKS; k++) begin
			compare_lease($sformatf("leases[%0d]", k), model_leases[k], DUT.leases[k]);
		end
	endtask

	// one clock cycle, entered and left at edge plus skew
	task automatic drive_cycle(input logic wr, input block_idx_t addr, input lease_t lease,
			input logic tick);
		update_i.write = wr;
		update_i.addr = addr;
		update_i.lease = lease;
		tick_i = tick;
		@(posedge clock_i);
		if (!resetn_i) begin
			model_leases = '0;
			exp_victim = '0;
		end else begin
			// victim register sees the table from before this edge
			exp_victim = expected_victim(model_leases);
			model_leases = next_leases(model_leases, update_i, tick_i);
		end
		#DRIVE_DELAY;
		check_state();
	endtask

	task automatic reset_sequence();
		resetn_i = 1'b0;
		repeat (10) begin
			drive_cycle(1'b0, '0, '0, 1'b0);
		end
		compare_victim("victim_o", make_victim(1'b0, 3'd0), victim_o);
		resetn_i = 1'b1;
		// all leases zero, so block 0 is expired right away
		drive_cycle(1'b0, '0, '0, 1'b0);
		compare_victim("victim_o", make_victim(1'b1, 3'd0), victim_o);
	endtask

	task automatic write_leases();
		drive_cycle(1'b1, 3'd0, 6'd5, 1'b0);
		drive_cycle(1'b1, 3'd1, 6'd12, 1'b0);
		drive_cycle(1'b1, 3'd2, 6'd9, 1'b0);
		drive_cycle(1'b1, 3'd3, 6'd12, 1'b0);
		drive_cycle(1'b1, 3'd4, 6'd1, 1'b0);
		drive_cycle(1'b1, 3'd5, 6'd2, 1'b0);
		drive_cycle(1'b1, 3'd6, 6'd7, 1'b0);
		drive_cycle(1'b1, 3'd7, 6'd6, 1'b0);
		drive_cycle(1'b0, '0, '0, 1'b0);
		// bit 3 is top, blocks 1 2 3 have it
		compare_victim("victim_o", make_victim(1'b0, 3'd1), victim_o);
		drive_cycle(1'b1, 3'd2, 6'd31, 1'b0);
		drive_cycle(1'b1, 3'd6, 6'd32, 1'b0);
		drive_cycle(1'b0, '0, '0, 1'b0);
		// a lone 32 beats 31
		compare_victim("victim_o", make_victim(1'b0, 3'd6), victim_o);
	endtask

	task automatic count_down();
		for (int k = 0; k < N_BLOCKS; k++) begin
			if (k == 3 || k == 5) begin
				drive_cycle(1'b1, block_idx_t'(k), 6'd2, 1'b0);
			end else begin
				drive_cycle(1'b1, block_idx_t'(k), lease_t'(k + 4), 1'b0);
			end
		end
		repeat (2) begin
			drive_cycle(1'b0, '0, '0, 1'b1);
		end
		drive_cycle(1'b0, '0, '0, 1'b0);
		// blocks 3 and 5 hit zero together
		compare_victim("victim_o", make_victim(1'b1, 3'd3), victim_o);
		// run everything down and past zero
		repeat (16) begin
			drive_cycle(1'b0, '0, '0, 1'b1);
		end
		compare_lease("leases[3]", '0, DUT.leases[3]);
		compare_lease("leases[7]", '0, DUT.leases[7]);
		drive_cycle(1'b0, '0, '0, 1'b0);
		compare_victim("victim_o", make_victim(1'b1, 3'd0), victim_o);
	endtask

	task automatic write_beats_tick();
		for (int k = 0; k < N_BLOCKS; k++) begin
			drive_cycle(1'b1, block_idx_t'(k), 6'd20, 1'b0);
		end
		drive_cycle(1'b1, 3'd4, 6'd40, 1'b1);
		compare_lease("leases[4]", 6'd40, DUT.leases[4]);
		compare_lease("leases[0]", 6'd19, DUT.leases[0]);
		drive_cycle(1'b0, '0, '0, 1'b0);
		compare_victim("victim_o", make_victim(1'b0, 3'd4), victim_o);
	endtask

	task automatic random_traffic();
		logic       wr;
		logic       tick;
		block_idx_t addr;
		lease_t     lease;
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			wr = (($urandom % 2) == 1);
			tick = (($urandom % 3) != 0);
			addr = block_idx_t'($urandom % N_BLOCKS);
			lease = lease_t'($urandom);
			// zero loads now and then, to get expired blocks early
			if (($urandom % 4) == 0) begin
				lease = '0;
			end
			drive_cycle(wr, addr, lease, tick);
		end
	endtask

	// cycle limit
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock_i);
			cycle_count++;
		end
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hd489d990));
		error_count = 0;
		resetn_i = 1'b0;
		update_i = '0;
		tick_i = 1'b0;
		model_leases = '0;
		exp_victim = '0;
		reset_sequence();
		write_leases();
		count_down();
		write_beats_tick();
		random_traffic();
		$display("%0d errors after %0d cycles", error_count, cycle_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- tb.f
rtl/lease_pkg.sv
rtl/lowest_index_encoder.sv
rtl/lease_register_file.sv
rtl/approx_lease_selector.sv
rtl/victim_arbiter.sv
rtl/lease_cache_top.sv
test/lease_cache_assert.sv
test/tb_lease_cache.sv

//--- run.sh
#!/bin/sh
# build and run the lease cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f tb.f \
	--top-module tb_lease_cache \
	-Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_lease_cache)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# pass only if the testbench printed its pass line
if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
